// File: flist.f
lbp_pkg.sv
window_fetch.sv
lbp_encode.sv
result_writer.sv
mem_arbiter.sv
lbp_top.sv
lbp_asserts.sv
tb_lbp.sv

// File: lbp_asserts.sv
module lbp_asserts
    import lbp_pkg::*;
(
    input logic  aclk,
    input logic  rst,
    input logic  mem_valid,
    input logic  mem_write,
    input addr_t mem_addr,
    input pix_t  mem_wdata,
    input logic  mem_ready,
    input logic  done
);

    // Stalled command holds until accepted
    assert property (@(posedge aclk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_write) && $stable(mem_addr))
        else $error("command changed while stalled");

    assert property (@(posedge aclk) disable iff (rst)
        mem_valid && mem_write && !mem_ready |=> $stable(mem_wdata))
        else $error("write data changed while stalled");

    assert property (@(posedge aclk) $fell(rst) |-> !mem_valid && !done)
        else $error("bus active right after reset");

    // One-cycle pulse
    assert property (@(posedge aclk) disable iff (rst) done |=> !done)
        else $error("done high for two cycles");

endmodule

bind lbp_top lbp_asserts u_asserts (
    .aclk      (aclk),
    .rst       (rst),
    .mem_valid (mem_valid),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .done      (done)
);

// File: lbp_encode.sv
module lbp_encode
    import lbp_pkg::*;
(
    input  logic    aclk,
    input  logic    rst,
    input  logic    win_valid,
    input  window_t win,
    input  addr_t   win_addr,
    output logic    win_ready,
    output logic    code_valid,
    output pix_t    code,
    output addr_t   code_addr,
    input  logic    code_ready
);

    pix_t nxt_code;

    assign win_ready = !code_valid || code_ready;

    // Window index skips the centre at 4
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            if (k < 4) begin
                nxt_code[k] = (win[k] >= win[4]);
            end else begin
                nxt_code[k] = (win[k+1] >= win[4]);
            end
        end
    end

    always_ff @(posedge aclk or posedge rst) begin
        if (rst) begin
            code_valid <= 1'b0;
        end else if (win_ready) begin
            code_valid <= win_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (win_valid && win_ready) begin
            code      <= nxt_code;
            code_addr <= win_addr;
        end
    end

endmodule

// File: lbp_pkg.sv
package lbp_pkg;

    // Image geometry
    localparam int IMG_W = 8;
    localparam int IMG_H = 8;

    localparam int PIX_W  = 8;
    localparam int ADDR_W = 7;

    // Word address of each region
    localparam int IN_BASE  = 0;
    localparam int OUT_BASE = 64;

    // Interior pixels only, border gets no code
    localparam int N_CODES = (IMG_W - 2) * (IMG_H - 2);

    typedef logic [PIX_W-1:0]  pix_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Index 0 is top-left, 4 the centre, 8 bottom-right
    typedef pix_t [8:0] window_t;

endpackage

// File: lbp_top.sv
module lbp_top
    import lbp_pkg::*;
(
    input  logic  aclk,
    input  logic  rst,
    input  logic  start,
    output logic  done,
    output logic  mem_valid,
    output logic  mem_write,
    output addr_t mem_addr,
    output pix_t  mem_wdata,
    input  logic  mem_ready,
    input  logic  mem_rvalid,
    input  pix_t  mem_rdata
);

    logic    fetch_busy;
    logic    rd_valid;
    addr_t   rd_addr;
    logic    rd_ready;
    logic    win_valid;
    window_t win;
    addr_t   win_addr;
    logic    win_ready;
    logic    code_valid;
    pix_t    code;
    addr_t   code_addr;
    logic    code_ready;
    logic    wr_valid;
    addr_t   wr_addr;
    pix_t    wr_data;
    logic    wr_ready;

    window_fetch u_fetch (
        .aclk       (aclk),
        .rst        (rst),
        .start      (start),
        .busy       (fetch_busy),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rd_ready   (rd_ready),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .win_valid  (win_valid),
        .win        (win),
        .win_addr   (win_addr),
        .win_ready  (win_ready)
    );

    lbp_encode u_encode (
        .aclk       (aclk),
        .rst        (rst),
        .win_valid  (win_valid),
        .win        (win),
        .win_addr   (win_addr),
        .win_ready  (win_ready),
        .code_valid (code_valid),
        .code       (code),
        .code_addr  (code_addr),
        .code_ready (code_ready)
    );

    // Writer alone decides when the run is done
    result_writer u_writer (
        .aclk       (aclk),
        .rst        (rst),
        .fetch_busy (fetch_busy),
        .code_valid (code_valid),
        .code       (code),
        .code_addr  (code_addr),
        .code_ready (code_ready),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_ready   (wr_ready),
        .done       (done)
    );

    mem_arbiter u_arbiter (
        .aclk      (aclk),
        .rst       (rst),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_ready  (rd_ready),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_ready  (wr_ready),
        .mem_valid (mem_valid),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready)
    );

endmodule

// File: mem_arbiter.sv
module mem_arbiter
    import lbp_pkg::*;
(
    input  logic  aclk,
    input  logic  rst,
    input  logic  rd_valid,
    input  addr_t rd_addr,
    output logic  rd_ready,
    input  logic  wr_valid,
    input  addr_t wr_addr,
    input  pix_t  wr_data,
    output logic  wr_ready,
    output logic  mem_valid,
    output logic  mem_write,
    output addr_t mem_addr,
    output pix_t  mem_wdata,
    input  logic  mem_ready
);

    logic last_wr;
    logic lock;
    logic gnt_wr;

    // Stalled command keeps its grant, otherwise round robin on contention
    always_comb begin
        if (lock) begin
            gnt_wr = last_wr;
        end else if (rd_valid && wr_valid) begin
            gnt_wr = !last_wr;
        end else begin
            gnt_wr = wr_valid;
        end
    end

    assign mem_valid = gnt_wr ? wr_valid : rd_valid;
    assign mem_write = gnt_wr;
    assign mem_addr  = gnt_wr ? wr_addr : rd_addr;
    assign mem_wdata = wr_data;

    assign rd_ready = !gnt_wr && mem_ready;
    assign wr_ready = gnt_wr && mem_ready;

    always_ff @(posedge aclk or posedge rst) begin
        if (rst) begin
            last_wr <= 1'b0;
            lock    <= 1'b0;
        end else if (mem_valid) begin
            last_wr <= gnt_wr;
            lock    <= !mem_ready;
        end
    end

endmodule

// File: result_writer.sv
module result_writer
    import lbp_pkg::*;
(
    input  logic  aclk,
    input  logic  rst,
    input  logic  fetch_busy,
    input  logic  code_valid,
    input  pix_t  code,
    input  addr_t code_addr,
    output logic  code_ready,
    output logic  wr_valid,
    output addr_t wr_addr,
    output pix_t  wr_data,
    input  logic  wr_ready,
    output logic  done
);

    logic [$clog2(N_CODES+1)-1:0] wr_cnt;
    logic                         busy_q;
    logic                         wr_fire;

    assign code_ready = !wr_valid;
    assign wr_fire    = wr_valid && wr_ready;

    always_ff @(posedge aclk or posedge rst) begin
        if (rst) begin
            wr_valid <= 1'b0;
            wr_cnt   <= '0;
            busy_q   <= 1'b0;
            done     <= 1'b0;
        end else begin
            busy_q <= fetch_busy;
            done   <= 1'b0;
            if (code_valid && code_ready) begin
                wr_valid <= 1'b1;
            end else if (wr_ready) begin
                wr_valid <= 1'b0;
            end
            // Fresh run restarts the count
            if (fetch_busy && !busy_q) begin
                wr_cnt <= '0;
            end else if (wr_fire) begin
                if (wr_cnt == N_CODES - 1) begin
                    wr_cnt <= '0;
                    done   <= 1'b1;
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (code_valid && code_ready) begin
            wr_addr <= code_addr;
            wr_data <= code;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the LBP testbench with Verilator
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lbp -f flist.f \
    -o sim_lbp > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_lbp > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: tb_lbp.sv
module tb_lbp
    import lbp_pkg::*;
;

    localparam int DRV         = 10;
    localparam int N_TESTS     = 5;
    localparam int MEM_WORDS   = 128;
    localparam int CYCLE_LIMIT = N_TESTS * N_CODES * 9 * 8 * 2;

    localparam int K_CONST = 0;
    localparam int K_HRAMP = 1;
    localparam int K_VRAMP = 2;
    localparam int K_CHECK = 3;
    localparam int K_RAND  = 4;

    typedef struct {
        int   kind;
        int   ready_pct;
        int   exp_count;
        bit   has_code;
        pix_t exp_code;
    } entry_t;

    logic  aclk;
    logic  rst;
    logic  start;
    logic  done;
    logic  mem_valid;
    logic  mem_write;
    addr_t mem_addr;
    pix_t  mem_wdata;
    logic  mem_ready;
    logic  mem_rvalid;
    pix_t  mem_rdata;

    entry_t tests [N_TESTS];
    pix_t   mem [MEM_WORDS];
    pix_t   img [IMG_H][IMG_W];
    bit     written [IMG_W*IMG_H];
    int     wr_count;
    int     done_cnt;
    int     ready_pct;
    int     cycles;

    lbp_top UUT (
        .aclk       (aclk),
        .rst        (rst),
        .start      (start),
        .done       (done),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic pix_t pattern_pixel(input int kind, input int r, input int c);
        case (kind)
            K_CONST: return 8'h5A;
            K_HRAMP: return pix_t'(c * 29 + 3);
            K_VRAMP: return pix_t'(250 - r * 31);
            K_CHECK: return ((r + c) % 2 == 1) ? 8'hE0 : 8'h21;
            default: return pix_t'($urandom);
        endcase
    endfunction

    // Depends on all seven address bits
    function automatic pix_t marker(input int a);
        return pix_t'({a[6:0], 1'b1}) ^ 8'h5C;
    endfunction

    // Neighbours in row-major order, centre skipped
    function automatic pix_t expected_code(input int r, input int c);
        pix_t res;
        int   k;
        res = '0;
        k = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                if (!(dr == 0 && dc == 0)) begin
                    res[k] = (img[r+dr][c+dc] >= img[r][c]);
                    k++;
                end
            end
        end
        return res;
    endfunction

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge aclk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout: done was not seen within %0d cycles", CYCLE_LIMIT);
                $display("TEST FAIL");
                $fatal(1, "run stopped by cycle limit");
            end
        end
    end

    // Memory model, bus sampled at the falling edge
    initial begin
        logic rd_pending;
        int   rd_wait;
        pix_t rd_data;
        int   pos;
        mem_ready  = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        rd_pending = 1'b0;
        rd_wait    = 0;
        rd_data    = '0;
        forever begin
            @(negedge aclk);
            if (!rst && mem_valid && mem_ready) begin
                if (mem_write) begin
                    check_value(int'(mem_addr) >= OUT_BASE, 1, "write outside output region");
                    pos = int'(mem_addr) - OUT_BASE;
                    check_value((pos / IMG_W > 0) && (pos / IMG_W < IMG_H - 1) &&
                                (pos % IMG_W > 0) && (pos % IMG_W < IMG_W - 1), 1,
                                "write to a border position");
                    check_value(written[pos], 0, "output word written twice");
                    written[pos] = 1'b1;
                    wr_count++;
                    mem[mem_addr] = mem_wdata;
                end else begin
                    check_value(int'(mem_addr) < IN_BASE + IMG_W * IMG_H, 1,
                                "read outside input region");
                    check_value(rd_pending, 0, "second read while one outstanding");
                    rd_pending = 1'b1;
                    rd_data    = mem[mem_addr];
                    rd_wait    = 1 + int'($urandom % 3);
                end
            end
            if (!rst && done) begin
                check_value(wr_count, N_CODES, "write count when done rose");
                done_cnt++;
            end
            @(posedge aclk);
            #DRV;
            mem_rvalid = 1'b0;
            if (rd_pending) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    mem_rvalid = 1'b1;
                    mem_rdata  = rd_data;
                    rd_pending = 1'b0;
                end
            end
            mem_ready = (int'($urandom % 100) < ready_pct);
        end
    end

    initial begin
        pix_t exp;
        int   a;
        void'($urandom(32'hca9b));
        rst       = 1'b1;
        start     = 1'b0;
        wr_count  = 0;
        done_cnt  = 0;
        ready_pct = 100;
        tests[0] = '{K_CONST, 100, N_CODES, 1'b1, 8'hFF};
        tests[1] = '{K_HRAMP, 70, N_CODES, 1'b0, 8'h00};
        tests[2] = '{K_VRAMP, 50, N_CODES, 1'b0, 8'h00};
        tests[3] = '{K_CHECK, 35, N_CODES, 1'b0, 8'h00};
        tests[4] = '{K_RAND, 60, N_CODES, 1'b0, 8'h00};
        repeat (10) @(posedge aclk);
        #DRV;
        rst = 1'b0;

        for (int t = 0; t < N_TESTS; t++) begin
            for (int r = 0; r < IMG_H; r++) begin
                for (int c = 0; c < IMG_W; c++) begin
                    img[r][c] = pattern_pixel(tests[t].kind, r, c);
                    mem[IN_BASE + r * IMG_W + c] = img[r][c];
                    mem[OUT_BASE + r * IMG_W + c] = marker(OUT_BASE + r * IMG_W + c);
                    written[r * IMG_W + c] = 1'b0;
                end
            end
            wr_count  = 0;
            done_cnt  = 0;
            ready_pct = tests[t].ready_pct;

            @(posedge aclk);
            #DRV;
            start = 1'b1;
            @(posedge aclk);
            #DRV;
            start = 1'b0;
            while (done_cnt == 0) begin
                @(posedge aclk);
            end
            // Idle window to catch late writes or a second done
            repeat (4) @(posedge aclk);
            check_value(done_cnt, 1, $sformatf("done pulses in entry %0d", t));
            check_value(wr_count, tests[t].exp_count, $sformatf("writes in entry %0d", t));

            for (int r = 0; r < IMG_H; r++) begin
                for (int c = 0; c < IMG_W; c++) begin
                    a = OUT_BASE + r * IMG_W + c;
                    if (r == 0 || r == IMG_H - 1 || c == 0 || c == IMG_W - 1) begin
                        exp = marker(a);
                    end else if (tests[t].has_code) begin
                        exp = tests[t].exp_code;
                    end else begin
                        exp = expected_code(r, c);
                    end
                    check_value(mem[a], exp,
                                $sformatf("entry %0d output at row %0d col %0d", t, r, c));
                    check_value(mem[IN_BASE + r * IMG_W + c], img[r][c],
                                $sformatf("entry %0d input at row %0d col %0d", t, r, c));
                end
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: window_fetch.sv
module window_fetch
    import lbp_pkg::*;
(
    input  logic    aclk,
    input  logic    rst,
    input  logic    start,
    output logic    busy,
    output logic    rd_valid,
    output addr_t   rd_addr,
    input  logic    rd_ready,
    input  logic    mem_rvalid,
    input  pix_t    mem_rdata,
    output logic    win_valid,
    output window_t win,
    output addr_t   win_addr,
    input  logic    win_ready
);

    // Centre of the window being assembled
    logic [$clog2(IMG_W)-1:0] col;
    logic [$clog2(IMG_H)-1:0] row;

    logic [3:0] rd_cnt;
    logic [3:0] pix_pos;
    logic       pend;
    logic       last_read;
    logic       pix_in;
    window_t    acc_win;
    window_t    acc_next;

    // Reads go column by column, top to bottom within a column
    always_comb begin
        int cc;
        int rr;
        cc = int'(rd_cnt) / 3;
        rr = int'(rd_cnt) % 3;
        pix_pos = 4'(rr * 3 + cc);
        rd_addr = addr_t'(IN_BASE + (int'(row) + rr - 1) * IMG_W + int'(col) + cc - 1);
    end

    assign last_read = (rd_cnt == 4'd8);
    assign pix_in    = pend && mem_rvalid;

    // Final read of a window holds off until the output register is free
    assign rd_valid = busy && !pend && !(last_read && win_valid);

    always_comb begin
        acc_next = acc_win;
        if (pix_in) begin
            acc_next[pix_pos] = mem_rdata;
        end
    end

    always_ff @(posedge aclk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            col       <= '0;
            row       <= '0;
            rd_cnt    <= '0;
            pend      <= 1'b0;
            win_valid <= 1'b0;
        end else begin
            if (win_valid && win_ready) begin
                win_valid <= 1'b0;
            end
            if (!busy) begin
                if (start) begin
                    busy   <= 1'b1;
                    col    <= 1;
                    row    <= 1;
                    rd_cnt <= '0;
                end
            end else if (rd_valid && rd_ready) begin
                pend <= 1'b1;
            end else if (pix_in) begin
                pend <= 1'b0;
                if (last_read) begin
                    win_valid <= 1'b1;
                    if (col == IMG_W - 2) begin
                        // New row needs a full window of reads
                        col    <= 1;
                        rd_cnt <= '0;
                        if (row == IMG_H - 2) begin
                            busy <= 1'b0;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        // Only the right column is fetched
                        col    <= col + 1'b1;
                        rd_cnt <= 4'd6;
                    end
                end else begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (pix_in) begin
            if (last_read) begin
                win      <= acc_next;
                win_addr <= addr_t'(OUT_BASE + int'(row) * IMG_W + int'(col));
                // Shift left, right column refills with the next reads
                for (int r = 0; r < 3; r++) begin
                    acc_win[r*3]   <= acc_next[r*3+1];
                    acc_win[r*3+1] <= acc_next[r*3+2];
                end
            end else begin
                acc_win <= acc_next;
            end
        end
    end

endmodule
